/* rtl/pcs_rx_pkg.sv */
package pcs_rx_pkg;

	localparam int err_cnt_width = 16;

	typedef logic [9:0] code_group_t; // Bit 9 is a, bit 0 is j
	typedef logic [7:0] rx_byte_t; // HGF in 7..5, EDCBA in 4..0
	typedef logic [err_cnt_width-1:0] err_cnt_t;
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [2:0] {
		loss_of_sync,
		comma_1,
		comma_2,
		sync_acquired,
		sync_err // Counting bad words while in sync
	} sync_state_t;

	// Comma patterns at bits abcdeif
	localparam logic [6:0] comma_pos = 7'b0011111;
	localparam logic [6:0] comma_neg = 7'b1100000;
	localparam rx_byte_t k28_5 = 8'hBC;

	// D21.5, balanced in both sub-blocks
	localparam code_group_t idle_code = 10'b1010101010;

	localparam int commas_to_sync = 3;
	localparam int errs_to_loss = 4;

	localparam apb_addr_t addr_ctrl = 8'h00;
	localparam apb_addr_t addr_status = 8'h04;
	localparam apb_addr_t addr_code_err = 8'h08;
	localparam apb_addr_t addr_disp_err = 8'h0C;

endpackage

/* rtl/comma_align.sv */
`timescale 1ns/1ps

module comma_align import pcs_rx_pkg::*; (
	input logic clk,
	input logic nreset,
	input code_group_t raw,
	input logic align_en,
	output code_group_t aligned,
	output logic comma_seen,
	output logic [3:0] offset
);

	code_group_t prev;
	logic [19:0] window; // Earliest bit at 19
	logic found;
	logic [3:0] found_off;

	function automatic logic is_comma(input logic [6:0] bits);
		return (bits == comma_pos) || (bits == comma_neg);
	endfunction

	assign window = {prev, raw};

	// Search from the top so the lowest offset wins
	always_comb begin
		found = 1'b0;
		found_off = 4'd0;
		for (int i = 9; i >= 0; i--) begin
			if (is_comma(window[19-i -: 7])) begin
				found = 1'b1;
				found_off = 4'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		prev <= raw;
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			offset <= 4'd0;
			aligned <= idle_code;
			comma_seen <= 1'b0;
		end else begin
			if (align_en && found)
				offset <= found_off; // Boundary only moves while hunting
			aligned <= window[19-offset -: 10];
			comma_seen <= is_comma(window[19-offset -: 7]);
		end
	end

endmodule

/* rtl/dec_8b10b.sv */
`timescale 1ns/1ps

module dec_8b10b import pcs_rx_pkg::*; (
	input logic clk,
	input logic nreset,
	input code_group_t code_in,
	output rx_byte_t data_out,
	output logic k_out,
	output logic code_error,
	output logic disp_error
);

	code_group_t latch;
	logic [5:0] c6; // abcdei
	logic [3:0] c4; // fghj
	logic [3:0] c4_dec;
	logic [4:0] d5;
	logic [2:0] d3;
	logic bad6;
	logic bad4;
	logic alt7;
	logic k28;
	logic kx7;
	logic a7_ok;
	logic [2:0] ones6;
	logic [2:0] ones4;
	logic rd; // 1 is positive running disparity
	logic rd_mid;
	logic rd_next;
	logic err6_rd;
	logic err4_rd;

	assign c6 = latch[9:4];
	assign c4 = latch[3:0];
	assign k28 = (c6 == 6'b001111) || (c6 == 6'b110000);
	// K28 from positive RD carries fghj inverted
	assign c4_dec = (c6 == 6'b110000) ? ~c4 : c4;

	always_comb begin
		d5 = 5'd0;
		bad6 = 1'b0;
		case (c6)
			6'b100111, 6'b011000: d5 = 5'd0;
			6'b011101, 6'b100010: d5 = 5'd1;
			6'b101101, 6'b010010: d5 = 5'd2;
			6'b110001: d5 = 5'd3;
			6'b110101, 6'b001010: d5 = 5'd4;
			6'b101001: d5 = 5'd5;
			6'b011001: d5 = 5'd6;
			6'b111000, 6'b000111: d5 = 5'd7;
			6'b111001, 6'b000110: d5 = 5'd8;
			6'b100101: d5 = 5'd9;
			6'b010101: d5 = 5'd10;
			6'b110100: d5 = 5'd11;
			6'b001101: d5 = 5'd12;
			6'b101100: d5 = 5'd13;
			6'b011100: d5 = 5'd14;
			6'b010111, 6'b101000: d5 = 5'd15;
			6'b011011, 6'b100100: d5 = 5'd16;
			6'b100011: d5 = 5'd17;
			6'b010011: d5 = 5'd18;
			6'b110010: d5 = 5'd19;
			6'b001011: d5 = 5'd20;
			6'b101010: d5 = 5'd21;
			6'b011010: d5 = 5'd22;
			6'b111010, 6'b000101: d5 = 5'd23;
			6'b110011, 6'b001100: d5 = 5'd24;
			6'b100110: d5 = 5'd25;
			6'b010110: d5 = 5'd26;
			6'b110110, 6'b001001: d5 = 5'd27;
			6'b001110, 6'b001111, 6'b110000: d5 = 5'd28;
			6'b101110, 6'b010001: d5 = 5'd29;
			6'b011110, 6'b100001: d5 = 5'd30;
			6'b101011, 6'b010100: d5 = 5'd31;
			default: bad6 = 1'b1;
		endcase
	end

	always_comb begin
		d3 = 3'd0;
		bad4 = 1'b0;
		alt7 = 1'b0;
		case (c4_dec)
			4'b1011, 4'b0100: d3 = 3'd0;
			4'b1001: d3 = 3'd1;
			4'b0101: d3 = 3'd2;
			4'b1100, 4'b0011: d3 = 3'd3;
			4'b1101, 4'b0010: d3 = 3'd4;
			4'b1010: d3 = 3'd5;
			4'b0110: d3 = 3'd6;
			4'b1110, 4'b0001: d3 = 3'd7;
			4'b0111, 4'b1000: begin
				d3 = 3'd7;
				alt7 = 1'b1; // A7 or K.x.7
			end
			default: bad4 = 1'b1;
		endcase
	end

	// Sub-blocks where the alternate x.7 is allowed
	assign kx7 = !k28 && (d5 inside {5'd23, 5'd27, 5'd29, 5'd30});
	assign a7_ok = d5 inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20};

	assign ones6 = 3'($countones(c6));
	assign ones4 = 3'($countones(c4));

	// Each sub-block checked against the disparity it starts from
	always_comb begin
		err6_rd = 1'b0;
		rd_mid = rd;
		if (ones6 > 3'd3) begin
			err6_rd = rd;
			rd_mid = 1'b1;
		end else if (ones6 < 3'd3) begin
			err6_rd = !rd;
			rd_mid = 1'b0;
		end else if (c6 == 6'b111000) begin
			err6_rd = rd;
			rd_mid = 1'b0;
		end else if (c6 == 6'b000111) begin
			err6_rd = !rd;
			rd_mid = 1'b1;
		end

		err4_rd = 1'b0;
		rd_next = rd_mid;
		if (ones4 > 3'd2) begin
			err4_rd = rd_mid;
			rd_next = 1'b1;
		end else if (ones4 < 3'd2) begin
			err4_rd = !rd_mid;
			rd_next = 1'b0;
		end else if (c4 == 4'b1100) begin
			err4_rd = rd_mid;
			rd_next = 1'b0;
		end else if (c4 == 4'b0011) begin
			err4_rd = !rd_mid;
			rd_next = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			latch <= idle_code;
			rd <= 1'b0;
			data_out <= k28_5;
			k_out <= 1'b0;
			code_error <= 1'b0;
			disp_error <= 1'b0;
		end else begin
			latch <= code_in;
			rd <= rd_next;
			data_out <= {d3, d5};
			k_out <= k28 || (alt7 && kx7);
			code_error <= bad6 || bad4 || (alt7 && !k28 && !kx7 && !a7_ok);
			disp_error <= err6_rd || err4_rd;
		end
	end

endmodule

/* rtl/rx_sync_ctrl.sv */
`timescale 1ns/1ps

module rx_sync_ctrl import pcs_rx_pkg::*; (
	input logic clk,
	input logic nreset,
	input logic enable,
	input logic comma_seen,
	input logic k_out,
	input rx_byte_t data,
	input logic code_error,
	output logic align_en,
	output logic rx_sync,
	output logic rx_valid,
	output logic err_count_en
);

	sync_state_t state;
	sync_state_t state_next;
	logic [2:0] cnt; // Commas while acquiring, bad words while in sync
	logic [2:0] cnt_next;
	logic [1:0] comma_pipe; // Lines comma_seen up with decoder output
	logic good_comma;

	assign good_comma = comma_pipe[1] && k_out && (data == k28_5) && !code_error;

	always_comb begin
		state_next = state;
		cnt_next = cnt;
		case (state)
			loss_of_sync: begin
				cnt_next = 3'd1;
				if (good_comma)
					state_next = comma_1;
			end
			comma_1: begin
				cnt_next = 3'd2;
				state_next = good_comma ? comma_2 : loss_of_sync;
			end
			comma_2: begin
				cnt_next = cnt + 3'd1;
				if (!good_comma)
					state_next = loss_of_sync;
				else if (int'(cnt) + 1 == commas_to_sync)
					state_next = sync_acquired;
			end
			sync_acquired: begin
				cnt_next = 3'd1;
				if (code_error)
					state_next = sync_err;
			end
			sync_err: begin
				cnt_next = cnt + 3'd1;
				if (!code_error)
					state_next = sync_acquired;
				else if (int'(cnt) + 1 == errs_to_loss)
					state_next = loss_of_sync;
			end
			default: state_next = loss_of_sync;
		endcase
		if (!enable)
			state_next = loss_of_sync;
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= loss_of_sync;
			cnt <= 3'd0;
			comma_pipe <= 2'b00;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
			comma_pipe <= {comma_pipe[0], comma_seen};
		end
	end

	assign align_en = (state == loss_of_sync);
	assign rx_sync = (state == sync_acquired) || (state == sync_err);
	assign rx_valid = rx_sync && !code_error;
	assign err_count_en = rx_sync; // Errors only count once in sync

endmodule

/* rtl/rx_apb_regs.sv */
`timescale 1ns/1ps

module rx_apb_regs import pcs_rx_pkg::*; (
	input logic clk,
	input logic nreset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_addr_t paddr,
	input apb_data_t pwdata,
	output apb_data_t prdata,
	input logic sync,
	input logic [3:0] offset,
	input logic count_en,
	input logic code_error,
	input logic disp_error,
	output logic enable
);

	logic wr_en;
	logic rd_en;
	err_cnt_t code_cnt;
	err_cnt_t disp_cnt;

	// Clear wins over a same-cycle error, count sticks at all ones
	function automatic err_cnt_t cnt_update(input err_cnt_t cnt, input logic clr,
		input logic inc);
		if (clr)
			return '0;
		if (inc && (cnt != '1))
			return cnt + 1'b1;
		return cnt;
	endfunction

	assign wr_en = psel && penable && pwrite; // Access phase only
	assign rd_en = psel && penable && !pwrite;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			enable <= 1'b1;
			code_cnt <= '0;
			disp_cnt <= '0;
		end else begin
			if (wr_en && (paddr == addr_ctrl))
				enable <= pwdata[0];
			code_cnt <= cnt_update(code_cnt, wr_en && (paddr == addr_code_err),
				count_en && code_error);
			disp_cnt <= cnt_update(disp_cnt, wr_en && (paddr == addr_disp_err),
				count_en && disp_error);
		end
	end

	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (paddr)
				addr_ctrl: prdata = apb_data_t'(enable);
				addr_status: prdata = {24'd0, offset, 3'd0, sync};
				addr_code_err: prdata = apb_data_t'(code_cnt);
				addr_disp_err: prdata = apb_data_t'(disp_cnt);
				default: prdata = '0;
			endcase
		end
	end

endmodule

/* rtl/pcs_rx_top.sv */
`timescale 1ns/1ps

module pcs_rx_top import pcs_rx_pkg::*; (
	input logic clk,
	input logic nreset,
	input code_group_t rx_data,
	output rx_byte_t rx_byte,
	output logic rx_k,
	output logic rx_valid,
	output logic rx_sync,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_addr_t paddr,
	input apb_data_t pwdata,
	output apb_data_t prdata
);

	code_group_t aligned;
	logic comma_seen;
	logic align_en;
	logic [3:0] offset;
	rx_byte_t code_group;
	logic k_out;
	logic code_error;
	logic disp_error;
	logic enable;
	logic err_count_en;

	assign rx_byte = code_group;
	assign rx_k = k_out;

	comma_align u_align (
		.clk(clk),
		.nreset(nreset),
		.raw(rx_data),
		.align_en(align_en),
		.aligned(aligned),
		.comma_seen(comma_seen),
		.offset(offset)
	);

	dec_8b10b u_dec (
		.clk(clk),
		.nreset(nreset),
		.code_in(aligned),
		.data_out(code_group),
		.k_out(k_out),
		.code_error(code_error),
		.disp_error(disp_error)
	);

	rx_sync_ctrl u_sync (
		.clk(clk),
		.nreset(nreset),
		.enable(enable),
		.comma_seen(comma_seen),
		.k_out(k_out),
		.data(code_group),
		.code_error(code_error),
		.align_en(align_en),
		.rx_sync(rx_sync),
		.rx_valid(rx_valid),
		.err_count_en(err_count_en)
	);

	rx_apb_regs u_regs (
		.clk(clk),
		.nreset(nreset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.sync(rx_sync),
		.offset(offset),
		.count_en(err_count_en),
		.code_error(code_error),
		.disp_error(disp_error),
		.enable(enable)
	);

endmodule

/* bench/enc_8b10b_model.svh */
`ifndef ENC_8B10B_MODEL_SVH
`define ENC_8B10B_MODEL_SVH

// 5b/6b code at negative running disparity, abcdei
function automatic logic [5:0] enc6(input logic [4:0] x, input logic rd);
	logic [5:0] lut [32];
	logic [5:0] c;
	lut = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001,
		6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100,
		6'b011100, 6'b010111, 6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011,
		6'b101010, 6'b011010, 6'b111010, 6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011};
	c = lut[x];
	if (rd && (($countones(c) != 3) || (c == 6'b111000)))
		c = ~c; // Positive RD takes the complement
	return c;
endfunction

// 3b/4b code at negative running disparity, fghj
function automatic logic [3:0] enc4(input logic [2:0] y, input logic alt, input logic rd);
	logic [3:0] lut [8];
	logic [3:0] c;
	lut = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
	c = (alt && (y == 3'd7)) ? 4'b0111 : lut[y];
	if (rd && (($countones(c) != 2) || (c == 4'b1100)))
		c = ~c;
	return c;
endfunction

function automatic logic rd_after6(input logic [5:0] c, input logic rd);
	if (($countones(c) > 3) || (c == 6'b000111))
		return 1'b1;
	if (($countones(c) < 3) || (c == 6'b111000))
		return 1'b0;
	return rd;
endfunction

function automatic logic rd_after4(input logic [3:0] c, input logic rd);
	if (($countones(c) > 2) || (c == 4'b0011))
		return 1'b1;
	if (($countones(c) < 2) || (c == 4'b1100))
		return 1'b0;
	return rd;
endfunction

function automatic logic rd_after(input code_group_t g, input logic rd);
	return rd_after4(g[3:0], rd_after6(g[9:4], rd));
endfunction

function automatic code_group_t encode(input rx_byte_t b, input logic k, input logic rd);
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6;
	logic mid;
	logic alt;
	code_group_t g;
	x = b[4:0];
	y = b[7:5];
	if (k && (x == 5'd28)) begin
		g = {6'b001111, enc4(y, y == 3'd7, 1'b1)}; // K28 negative form
		return rd ? ~g : g;
	end
	c6 = enc6(x, rd);
	mid = rd_after6(c6, rd);
	alt = k || (!mid && (x inside {5'd17, 5'd18, 5'd20}))
		|| (mid && (x inside {5'd11, 5'd13, 5'd14}));
	return {c6, enc4(y, alt, mid)};
endfunction

// Bit stream, a first, with the end bit of each group noted
function automatic void push_group(input code_group_t g, input exp_t e);
	for (int i = 9; i >= 0; i--)
		bit_q.push_back(g[i]);
	bits_in += 10;
	end_q.push_back(bits_in - 1);
	info_q.push_back(e);
endfunction

// Cut the next raw word and report the group it completes
function automatic code_group_t pop_word(output exp_t e);
	code_group_t w;
	for (int i = 9; i >= 0; i--)
		w[i] = bit_q.pop_front();
	bits_out += 10;
	e = '0;
	if ((end_q.size() > 0) && (end_q[0] < bits_out)) begin
		void'(end_q.pop_front());
		e = info_q.pop_front();
	end
	return w;
endfunction

`endif

/* bench/tb_pcs_rx.sv */
`timescale 1ns/1ps

module tb_pcs_rx import pcs_rx_pkg::*; ();

	typedef struct packed {
		logic known;
		logic k;
		rx_byte_t b;
	} exp_t;

	localparam int max_cycles = 2000; // Full sequence runs a few hundred cycles
	localparam int chop_offset = 3;
	localparam rx_byte_t k_list [12] = '{8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC,
		8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE};

	logic clk;
	logic nreset;
	code_group_t rx_data;
	rx_byte_t rx_byte;
	logic rx_k;
	logic rx_valid;
	logic rx_sync;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;

	logic bit_q [$];
	int end_q [$];
	exp_t info_q [$];
	exp_t pipe_q [$]; // Three cycles from raw word to decoded byte
	int bits_in;
	int bits_out;
	logic exp_known;
	logic exp_k;
	rx_byte_t exp_byte;
	logic stream_on;
	logic hold_off;
	logic enc_rd;
	int seed;
	int cycles;
	int valid_beats;
	code_group_t bad_group;

	`include "enc_8b10b_model.svh"

	pcs_rx_top dut (
		.clk(clk),
		.nreset(nreset),
		.rx_data(rx_data),
		.rx_byte(rx_byte),
		.rx_k(rx_k),
		.rx_valid(rx_valid),
		.rx_sync(rx_sync),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_now();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
		assert (got == exp) else begin
			$display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
			fail_now();
		end
	endtask

	function automatic void send(input rx_byte_t b, input logic k);
		code_group_t g;
		exp_t e;
		g = encode(b, k, enc_rd);
		enc_rd = rd_after(g, enc_rd);
		e.known = 1'b1;
		e.k = k;
		e.b = b;
		push_group(g, e);
	endfunction

	task automatic apb_read(input apb_addr_t a, output apb_data_t d);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = a;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		d = prdata; // Mid access phase
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t a, input apb_data_t d);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = a;
		pwdata = d;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_check(input apb_addr_t a, input apb_data_t exp, input string name);
		apb_data_t d;
		apb_read(a, d);
		check_value(name, d, exp);
	endtask

	// Until every group queued so far has left the pipeline
	task automatic drain();
		int mark;
		mark = bits_in;
		while (bits_out < mark)
			@(posedge clk);
		repeat (5) @(posedge clk);
	endtask

	task automatic wait_sync(input logic level);
		while (rx_sync !== level)
			@(posedge clk);
	endtask

	// Raw word driver, idles on commas
	always @(posedge clk) begin
		exp_t e;
		if (stream_on) begin
			#1;
			if (bit_q.size() < 10)
				send(k28_5, 1'b1);
			rx_data = pop_word(e);
			pipe_q.push_back(e);
			if (pipe_q.size() > 3) begin
				e = pipe_q.pop_front();
				exp_known = e.known;
				exp_k = e.k;
				exp_byte = e.b;
			end
		end
	end

	always @(posedge clk) begin
		if (nreset && rx_valid && !rx_k)
			valid_beats++; // Data bytes only
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			fail_now();
		end
	end

	assert property (@(posedge clk) disable iff (!nreset) rx_valid |-> exp_known)
		else begin
			$display("** Error at %0t: rx_valid high where no code group was sent", $time);
			fail_now();
		end
	assert property (@(posedge clk) disable iff (!nreset) rx_valid |-> (rx_byte == exp_byte))
		else begin
			$display("** Error at %0t: rx_byte expected %02h got %02h", $time,
				$sampled(exp_byte), $sampled(rx_byte));
			fail_now();
		end
	assert property (@(posedge clk) disable iff (!nreset) rx_valid |-> (rx_k == exp_k))
		else begin
			$display("** Error at %0t: rx_k expected %0b got %0b", $time,
				$sampled(exp_k), $sampled(rx_k));
			fail_now();
		end
	assert property (@(posedge clk) disable iff (!nreset) hold_off |-> !rx_sync)
		else begin
			$display("** Error at %0t: rx_sync expected 0 got 1", $time);
			fail_now();
		end

	initial begin
		seed = 45;
		rx_data = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		nreset = 1'b0;
		stream_on = 1'b0;
		hold_off = 1'b0;
		enc_rd = 1'b0;
		bits_in = 0;
		bits_out = 0;
		exp_known = 1'b0;
		exp_k = 1'b0;
		exp_byte = '0;
		cycles = 0;
		valid_beats = 0;
		bad_group = '0;
		repeat (3) pipe_q.push_back('0);
		for (int i = 0; i < chop_offset; i++) begin
			bit_q.push_back((i % 2) == 0); // Shifts the word boundary
			bits_in++;
		end
		repeat (5) @(posedge clk);
		#1;
		nreset = 1'b1;

		check_value("rx_sync", apb_data_t'(rx_sync), 0);
		check_value("rx_valid", apb_data_t'(rx_valid), 0);
		read_check(addr_code_err, 0, "code_err");
		read_check(addr_disp_err, 0, "disp_err");
		read_check(addr_ctrl, 1, "ctrl");
		read_check(addr_status, 0, "status");

		stream_on = 1'b1;
		repeat (6) send(k28_5, 1'b1);
		wait_sync(1'b1);
		read_check(addr_status, {24'd0, 4'(chop_offset), 4'd1}, "status");
		valid_beats = 0;
		for (int i = 0; i < 40; i++)
			send(rx_byte_t'($random(seed)), 1'b0);
		drain();
		check_value("rx_valid data bytes", apb_data_t'(valid_beats), 40);

		valid_beats = 0;
		foreach (k_list[i]) begin
			send(k_list[i], 1'b1);
			send(rx_byte_t'($random(seed)), 1'b0);
		end
		drain();
		check_value("rx_valid data bytes", apb_data_t'(valid_beats), 12);
		read_check(addr_code_err, 0, "code_err");
		read_check(addr_disp_err, 0, "disp_err");

		// D0.0 in the variant for the other running disparity
		bad_group = encode(8'h00, 1'b0, !enc_rd);
		push_group(bad_group, '{1'b1, 1'b0, 8'h00});
		enc_rd = rd_after(bad_group, !enc_rd);
		drain();
		read_check(addr_disp_err, 1, "disp_err");
		read_check(addr_code_err, 0, "code_err");

		repeat (4) push_group('0, '0);
		enc_rd = 1'b0; // All zeros leave disparity negative
		wait_sync(1'b0);
		read_check(addr_code_err, 4, "code_err");
		apb_write(addr_code_err, 32'h1);
		read_check(addr_code_err, 0, "code_err");
		repeat (6) send(k28_5, 1'b1);
		wait_sync(1'b1);

		apb_write(addr_ctrl, 0);
		wait_sync(1'b0);
		hold_off = 1'b1;
		repeat (8) send(k28_5, 1'b1);
		drain();
		hold_off = 1'b0;
		read_check(addr_ctrl, 0, "ctrl");
		apb_write(addr_ctrl, 1);
		repeat (6) send(k28_5, 1'b1);
		wait_sync(1'b1);

		$display("All tests passed!");
		$finish;
	end

endmodule

/* tb.f */
+incdir+bench
rtl/pcs_rx_pkg.sv
rtl/comma_align.sv
rtl/dec_8b10b.sv
rtl/rx_sync_ctrl.sv
rtl/rx_apb_regs.sv
rtl/pcs_rx_top.sv
bench/tb_pcs_rx.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_pcs_rx -o sim_pcs_rx
	-./obj_dir/sim_pcs_rx > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif grep -q "All tests passed!" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
